// File: design/regset_pkg.sv
// --------------------
// shared constants for the SPI register block
// frame is 8-bit command then 24-bit data, MSB first
// addresses are 6 bits, only 7, 8 and 9 are mapped
// --------------------
package regset_pkg;

  // frame layout
  localparam int frame_bits = 32;     // full frame, command plus data
  localparam int cmd_bits   = 8;      // opcode and address
  localparam int addr_bits  = 6;
  localparam int data_bits  = 24;

  // register map
  localparam logic [addr_bits-1:0] addr_led     = 6'd7;
  localparam logic [addr_bits-1:0] addr_spi_mux = 6'd8;
  localparam logic [addr_bits-1:0] addr_4094    = 6'd9;

  // reset and readback values
  localparam logic [data_bits-1:0] led_reset        = 24'h000015;
  localparam logic [data_bits-1:0] unknown_readback = 24'h003039;  // 12345 decimal

  // top two command bits
  typedef enum logic [1:0] {
    op_write  = 2'd0,   // replace
    op_set    = 2'd1,   // or in mask
    op_clear  = 2'd2,   // and with inverted mask
    op_toggle = 2'd3    // xor with mask
  } reg_op_e;

endpackage

// File: design/spi_rx.sv
// --------------------
// SPI mode 0 receiver, pins sampled in the cs domain
// sck half period must be at least 4 cs cycles
// only a frame of exactly 32 bits raises commit
// end of any frame past the command byte is flagged by
// cmd_strobe and sdo_shift high in the same cycle
// --------------------
module spi_rx (
  input  logic                                     cs,
  input  logic                                     rst_n,
  input  logic                                     sck,
  input  logic                                     ss_n,
  input  logic                                     sdi,
  output logic                                     cmd_strobe,
  output regset_pkg::reg_op_e                      op,
  output logic [regset_pkg::addr_bits-1:0]         addr,
  output logic                                     sdo_shift,
  output logic                                     commit,
  output logic [regset_pkg::data_bits-1:0]         wdata
);

  logic [1:0]  sck_q;        // two-stage synchronizers
  logic [1:0]  ss_q;
  logic [1:0]  sdi_q;
  logic        sck_d;        // previous synchronized sck
  logic        ss_d;         // previous synchronized ss_n
  logic        sck_rise;
  logic        sck_fall;
  logic        ss_rise;
  logic        frame_end;    // one cycle after ss_n rise, frame had a command
  logic [5:0]  bit_cnt;      // saturates, so 33+ bit frames never look complete
  logic [regset_pkg::frame_bits-1:0] shreg;
  logic [regset_pkg::cmd_bits-1:0]   cmd_byte;

  assign sck_rise = sck_q[1] & ~sck_d;
  assign sck_fall = ~sck_q[1] & sck_d;
  assign ss_rise  = ss_q[1] & ~ss_d;

  // command byte as it completes on the 8th rising edge
  assign cmd_byte = {shreg[regset_pkg::cmd_bits-2:0], sdi_q[1]};

  // data word is the last 24 bits shifted in
  assign wdata = shreg[regset_pkg::data_bits-1:0];

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q <= 2'b00;
      ss_q  <= 2'b11;        // deselected
      sdi_q <= 2'b00;
      sck_d <= 1'b0;
      ss_d  <= 1'b1;
    end
    else
    begin
      sck_q <= {sck_q[0], sck};
      ss_q  <= {ss_q[0], ss_n};
      sdi_q <= {sdi_q[0], sdi};
      sck_d <= sck_q[1];
      ss_d  <= ss_q[1];
    end
  end

  // frame bits enter at the bottom, MSB first
  always_ff @(posedge cs)
  begin
    if (!ss_q[1] && sck_rise)
      shreg <= {shreg[regset_pkg::frame_bits-2:0], sdi_q[1]};
  end

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt    <= '0;
      cmd_strobe <= 1'b0;
      sdo_shift  <= 1'b0;
      commit     <= 1'b0;
      frame_end  <= 1'b0;
      op         <= regset_pkg::op_write;
      addr       <= '0;
    end
    else
    begin
      cmd_strobe <= 1'b0;    // default, strobes last one cycle
      sdo_shift  <= 1'b0;
      commit     <= 1'b0;
      frame_end  <= 1'b0;
      if (ss_q[1])
        bit_cnt <= '0;       // idle between frames
      else if (sck_rise)
      begin
        if (bit_cnt != '1)
          bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == 6'(regset_pkg::cmd_bits - 1))
        begin
          cmd_strobe <= 1'b1;                                   // 8th bit arriving
          op         <= regset_pkg::reg_op_e'(cmd_byte[7:6]);
          addr       <= cmd_byte[regset_pkg::addr_bits-1:0];
        end
      end
      else if (sck_fall && bit_cnt > 6'(regset_pkg::cmd_bits) &&
               bit_cnt < 6'(regset_pkg::frame_bits))
        sdo_shift <= 1'b1;   // next read bit, after rising edges 9..31
      if (ss_rise && bit_cnt == 6'(regset_pkg::frame_bits))
        commit <= 1'b1;      // bit_cnt still holds the old count here
      if (ss_rise && bit_cnt >= 6'(regset_pkg::cmd_bits))
        frame_end <= 1'b1;
      if (frame_end)
      begin
        cmd_strobe <= 1'b1;  // paired strobes tell spi_tx to drop its data
        sdo_shift  <= 1'b1;
      end
    end
  end

  // end marker is delayed by one cycle so it cannot land on commit
  a_strobe_commit : assert property (@(posedge cs) disable iff (!rst_n)
    !(cmd_strobe && commit));

endmodule

// File: design/spi_tx.sv
// --------------------
// readback shifter for sdo
// sdo is 0 outside the read part of a frame
// cmd_strobe with sdo_shift together clears it
// --------------------
module spi_tx (
  input  logic                              cs,
  input  logic                              rst_n,
  input  logic                              cmd_strobe,
  input  logic                              sdo_shift,
  input  logic [regset_pkg::data_bits-1:0]  rdata,
  output logic                              sdo
);

  logic [regset_pkg::data_bits-1:0] shreg;
  logic                             active;     // between load and frame end
  logic [4:0]                       shift_cnt;  // shifts since load
  logic                             end_mark;

  assign end_mark = cmd_strobe & sdo_shift;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg     <= '0;
      active    <= 1'b0;
      shift_cnt <= '0;
    end
    else if (end_mark)
    begin
      shreg     <= '0;       // frame over, sdo back to 0
      active    <= 1'b0;
      shift_cnt <= '0;
    end
    else if (cmd_strobe)
    begin
      shreg     <= rdata;    // bit 23 goes straight out
      active    <= 1'b1;
      shift_cnt <= '0;
    end
    else if (sdo_shift && active && shift_cnt != 5'(regset_pkg::data_bits - 1))
    begin
      shreg     <= {shreg[regset_pkg::data_bits-2:0], 1'b0};  // zero fill
      shift_cnt <= shift_cnt + 5'd1;
    end
  end

  // after 23 shifts bit 0 sits on top until the frame ends
  assign sdo = active & shreg[regset_pkg::data_bits-1];

  // shifts only come after the command byte loaded the word
  a_shift_after_load : assert property (@(posedge cs) disable iff (!rst_n)
    (sdo_shift && !cmd_strobe) |-> active);

endmodule

// File: design/reg_bank.sv
// --------------------
// three 24-bit control registers
// write, set, clear, toggle applied on commit
// unmapped addresses read 24'h003039, writes ignored
// --------------------
module reg_bank (
  input  logic                              cs,
  input  logic                              rst_n,
  input  logic [regset_pkg::addr_bits-1:0]  addr,
  input  regset_pkg::reg_op_e               op,
  input  logic                              commit,
  input  logic [regset_pkg::data_bits-1:0]  wdata,
  output logic [regset_pkg::data_bits-1:0]  rdata,
  output logic [regset_pkg::data_bits-1:0]  reg_led,
  output logic [regset_pkg::data_bits-1:0]  reg_spi_mux,
  output logic [regset_pkg::data_bits-1:0]  reg_4094
);

  // new register value from old value and the data word
  function automatic logic [regset_pkg::data_bits-1:0] apply_op(
    input regset_pkg::reg_op_e              f_op,
    input logic [regset_pkg::data_bits-1:0] old_val,
    input logic [regset_pkg::data_bits-1:0] mask
  );
    logic [regset_pkg::data_bits-1:0] new_val;
    case (f_op)
      regset_pkg::op_write:  new_val = mask;
      regset_pkg::op_set:    new_val = old_val | mask;
      regset_pkg::op_clear:  new_val = old_val & ~mask;
      regset_pkg::op_toggle: new_val = old_val ^ mask;
      default:               new_val = old_val;
    endcase
    return new_val;
  endfunction

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_led     <= regset_pkg::led_reset;
      reg_spi_mux <= '0;     // no device selected
      reg_4094    <= '0;
    end
    else if (commit)
    begin
      case (addr)
        regset_pkg::addr_led:
          reg_led <= apply_op(op, reg_led, wdata);
        regset_pkg::addr_spi_mux:
          reg_spi_mux <= apply_op(op, reg_spi_mux, wdata);
        regset_pkg::addr_4094:
          reg_4094 <= apply_op(op, reg_4094, wdata);
        default:
          ;                  // unmapped, nothing changes
      endcase
    end
  end

  // read mux, addr is held from the command byte
  always_comb
  begin
    case (addr)
      regset_pkg::addr_led:     rdata = reg_led;
      regset_pkg::addr_spi_mux: rdata = reg_spi_mux;
      regset_pkg::addr_4094:    rdata = reg_4094;
      default:                  rdata = regset_pkg::unknown_readback;
    endcase
  end

  // op comes from spi_rx, must be settled by the time ss_n rise commits
  a_op_known : assert property (@(posedge cs) disable iff (!rst_n)
    commit |-> !$isunknown(op));

endmodule

// File: design/spi_reg_set.sv
// --------------------
// SPI configured register block, top level
// all SPI pins synchronized into cs
// register outputs change 4 cs cycles after ss_n rises
// --------------------
module spi_reg_set (
  input  logic                              cs,
  input  logic                              rst_n,
  input  logic                              sck,
  input  logic                              ss_n,     // chip select, active low
  input  logic                              sdi,
  output logic                              sdo,
  output logic [regset_pkg::data_bits-1:0]  reg_led,
  output logic [regset_pkg::data_bits-1:0]  reg_spi_mux,
  output logic [regset_pkg::data_bits-1:0]  reg_4094
);

  logic                              cmd_strobe;
  regset_pkg::reg_op_e               op;
  logic [regset_pkg::addr_bits-1:0]  addr;
  logic                              sdo_shift;
  logic                              commit;
  logic [regset_pkg::data_bits-1:0]  wdata;
  logic [regset_pkg::data_bits-1:0]  rdata;      // readback for the addressed reg

  spi_rx rx_i (
    .cs         (cs),
    .rst_n      (rst_n),
    .sck        (sck),
    .ss_n       (ss_n),
    .sdi        (sdi),
    .cmd_strobe (cmd_strobe),
    .op         (op),
    .addr       (addr),
    .sdo_shift  (sdo_shift),
    .commit     (commit),
    .wdata      (wdata)
  );

  spi_tx tx_i (
    .cs         (cs),
    .rst_n      (rst_n),
    .cmd_strobe (cmd_strobe),
    .sdo_shift  (sdo_shift),
    .rdata      (rdata),
    .sdo        (sdo)
  );

  reg_bank bank_i (
    .cs          (cs),
    .rst_n       (rst_n),
    .addr        (addr),
    .op          (op),
    .commit      (commit),
    .wdata       (wdata),
    .rdata       (rdata),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094)
  );

endmodule

// File: verification/tb_spi_reg_set.sv
// --------------------
// testbench for spi_reg_set, SPI mode 0 master on the pins
// sck half period is 4 cs cycles, pins change on falling cs
// register and sdo checks wait out the synchronizer latency
// after ss_n rises, checking is done by assertions
// --------------------
module tb_spi_reg_set;

  localparam int clk_period   = 40;
  localparam int half_sck     = 4;      // cs cycles per sck half period
  localparam int frame_gap    = 10;     // idle cs cycles after each frame
  localparam int commit_wait  = 4;      // ss_n rise to register outputs
  localparam int sdo_wait     = 5;      // ss_n rise to sdo back at 0
  localparam int n_frames     = 26;
  localparam int frame_budget = 40 * 2 * half_sck;  // 33 bits plus setup and gap
  localparam longint watchdog_time =
    longint'(n_frames * frame_budget + 200) * clk_period;

  logic        cs;
  logic        rst_n;
  logic        sck;
  logic        ss_n;
  logic        sdi;
  logic        sdo;
  logic [23:0] reg_led;
  logic [23:0] reg_spi_mux;
  logic [23:0] reg_4094;

  // reference model, updated when a full frame ends
  logic [23:0] shadow_led;
  logic [23:0] shadow_spi_mux;
  logic [23:0] shadow_4094;
  logic [5:0]  mapped_addr [3];
  logic [31:0] rng_state;
  int          idle_cnt = 0;    // cs cycles since ss_n went high
  int          sent_bits = 0;   // rising sck edges in the current frame
  int          error_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;

  spi_reg_set dut_i (
    .cs          (cs),
    .rst_n       (rst_n),
    .sck         (sck),
    .ss_n        (ss_n),
    .sdi         (sdi),
    .sdo         (sdo),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094)
  );

  initial cs = 1'b0;
  always #(clk_period / 2) cs = ~cs;

  always @(posedge cs)
  begin
    if (!ss_n)
      idle_cnt <= 0;
    else if (idle_cnt < 1000)
      idle_cnt <= idle_cnt + 1;   // saturates
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // what a frame to this address should read back
  function automatic logic [23:0] model_read(input logic [5:0] a);
    if (a == regset_pkg::addr_led)
      return shadow_led;
    else if (a == regset_pkg::addr_spi_mux)
      return shadow_spi_mux;
    else if (a == regset_pkg::addr_4094)
      return shadow_4094;
    return regset_pkg::unknown_readback;
  endfunction

  function automatic logic [23:0] model_apply(input regset_pkg::reg_op_e f_op,
                                              input logic [23:0] old_val,
                                              input logic [23:0] mask);
    if (f_op == regset_pkg::op_write)
      return mask;
    else if (f_op == regset_pkg::op_set)
      return old_val | mask;
    else if (f_op == regset_pkg::op_clear)
      return old_val & ~mask;
    return old_val ^ mask;            // toggle
  endfunction

  task automatic model_commit(input regset_pkg::reg_op_e f_op, input logic [5:0] a,
                              input logic [23:0] d);
    if (a == regset_pkg::addr_led)
      shadow_led = model_apply(f_op, shadow_led, d);
    else if (a == regset_pkg::addr_spi_mux)
      shadow_spi_mux = model_apply(f_op, shadow_spi_mux, d);
    else if (a == regset_pkg::addr_4094)
      shadow_4094 = model_apply(f_op, shadow_4094, d);
    // unmapped address, model unchanged
  endtask

  // one SPI frame of nbits bits, readback checked for frames of 32 or more
  task automatic spi_frame(input regset_pkg::reg_op_e f_op, input logic [5:0] a,
                           input logic [23:0] d, input int nbits);
    logic [31:0] word;
    logic [23:0] expect_rd;
    logic [23:0] got_rd;
    int          i;
    word      = {f_op, a, d};
    expect_rd = model_read(a);        // value held before the frame
    got_rd    = '0;
    @(negedge cs);
    sent_bits = 0;
    ss_n      = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      sdi = (i < 32) ? word[31 - i] : 1'b0;   // extra bits of a long frame are 0
      repeat (half_sck) @(negedge cs);
      if (i >= 8 && i < 32)
        got_rd[31 - i] = sdo;         // sampled just before rising sck
      sck       = 1'b1;
      sent_bits = i + 1;
      repeat (half_sck) @(negedge cs);
      sck = 1'b0;
    end
    repeat (half_sck) @(negedge cs);
    ss_n = 1'b1;
    sdi  = 1'b0;
    if (nbits == 32)
      model_commit(f_op, a, d);
    if (nbits >= 32)
    begin
      assert (got_rd == expect_rd)
      else
      begin
        error_cnt = error_cnt + 1;
        $display("error sdo readback addr 0x%02h: got 0x%06h expected 0x%06h",
                 a, got_rd, expect_rd);
      end
    end
    repeat (frame_gap) @(negedge cs);
  endtask

  // a set with an empty mask only reads
  task automatic read_reg(input logic [5:0] a);
    spi_frame(regset_pkg::op_set, a, 24'h000000, 32);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_cnt == errors_before)
    begin
      pass_cnt = pass_cnt + 1;
      $display("test %s: ok", name);
    end
    else
    begin
      fail_cnt = fail_cnt + 1;
      $display("test %s: failed with %0d errors", name, error_cnt - errors_before);
    end
  endtask

  // outputs follow the model once a frame has settled
  a_led : assert property (@(posedge cs) disable iff (!rst_n)
    (ss_n && idle_cnt >= commit_wait) |-> reg_led == shadow_led)
  else
  begin
    error_cnt = error_cnt + 1;
    $display("error reg_led: got 0x%06h expected 0x%06h",
             $sampled(reg_led), $sampled(shadow_led));
  end

  a_spi_mux : assert property (@(posedge cs) disable iff (!rst_n)
    (ss_n && idle_cnt >= commit_wait) |-> reg_spi_mux == shadow_spi_mux)
  else
  begin
    error_cnt = error_cnt + 1;
    $display("error reg_spi_mux: got 0x%06h expected 0x%06h",
             $sampled(reg_spi_mux), $sampled(shadow_spi_mux));
  end

  a_4094 : assert property (@(posedge cs) disable iff (!rst_n)
    (ss_n && idle_cnt >= commit_wait) |-> reg_4094 == shadow_4094)
  else
  begin
    error_cnt = error_cnt + 1;
    $display("error reg_4094: got 0x%06h expected 0x%06h",
             $sampled(reg_4094), $sampled(shadow_4094));
  end

  // sdo low while deselected and during the command byte
  a_sdo_idle : assert property (@(posedge cs) disable iff (!rst_n)
    ((ss_n && idle_cnt >= sdo_wait) || (!ss_n && sent_bits < regset_pkg::cmd_bits))
      |-> !sdo)
  else
  begin
    error_cnt = error_cnt + 1;
    $display("error sdo: got 0x%01h expected 0x0", $sampled(sdo));
  end

  initial
  begin
    int                  errs;
    int                  k;
    logic [5:0]          a;
    regset_pkg::reg_op_e f_op;
    rst_n          = 1'b0;
    sck            = 1'b0;
    ss_n           = 1'b1;
    sdi            = 1'b0;
    shadow_led     = regset_pkg::led_reset;
    shadow_spi_mux = '0;
    shadow_4094    = '0;
    mapped_addr[0] = regset_pkg::addr_led;
    mapped_addr[1] = regset_pkg::addr_spi_mux;
    mapped_addr[2] = regset_pkg::addr_4094;
    rng_state      = 32'hb60239a1;
    repeat (8) @(negedge cs);
    rst_n = 1'b1;

    errs = error_cnt;
    repeat (20) @(negedge cs);        // assertions see the reset values
    finish_test("reset values", errs);

    errs = error_cnt;
    for (k = 0; k < 3; k++)
    begin
      rng_state = xorshift32(rng_state);
      spi_frame(regset_pkg::op_write, mapped_addr[k], rng_state[23:0], 32);
    end
    for (k = 0; k < 3; k++)
      read_reg(mapped_addr[k]);
    finish_test("write and read back", errs);

    errs = error_cnt;
    for (k = 0; k < 12; k++)
    begin
      rng_state = xorshift32(rng_state);
      a    = mapped_addr[rng_state[27:24] % 3];
      f_op = regset_pkg::reg_op_e'(2'(1 + rng_state[31:28] % 3));  // set, clear, toggle
      spi_frame(f_op, a, rng_state[23:0], 32);
    end
    finish_test("set clear toggle", errs);

    errs = error_cnt;
    rng_state = xorshift32(rng_state);
    a = 6'(10 + rng_state[29:24] % 54);   // somewhere in 10..63
    read_reg(a);
    spi_frame(regset_pkg::op_write, a, rng_state[23:0], 32);
    read_reg(6'd0);
    finish_test("unmapped address", errs);

    errs = error_cnt;
    rng_state = xorshift32(rng_state);
    spi_frame(regset_pkg::op_write, regset_pkg::addr_led, rng_state[23:0], 20);
    rng_state = xorshift32(rng_state);
    spi_frame(regset_pkg::op_toggle, regset_pkg::addr_spi_mux, rng_state[23:0], 33);
    finish_test("aborted frames", errs);

    errs = error_cnt;
    spi_frame(regset_pkg::op_write, regset_pkg::addr_4094, 24'hffffff, 32);
    read_reg(regset_pkg::addr_4094);                 // sdo high for the whole word
    spi_frame(regset_pkg::op_set, regset_pkg::addr_4094, 24'h000000, 20);  // cut mid word
    repeat (frame_gap) @(negedge cs);
    finish_test("sdo idle", errs);

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && error_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_time);
    $display("timeout: the frames did not complete within %0d time units", watchdog_time);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: sim.f
design/regset_pkg.sv
design/spi_rx.sv
design/spi_tx.sv
design/reg_bank.sv
design/spi_reg_set.sv
verification/tb_spi_reg_set.sv

// File: Bender.yml
package:
  name: spi_reg_set

sources:
  - files:
      - design/regset_pkg.sv
      - design/spi_rx.sv
      - design/spi_tx.sv
      - design/reg_bank.sv
      - design/spi_reg_set.sv
  - target: test
    files:
      - verification/tb_spi_reg_set.sv
